//--- Makefile
# Verilator build and run of the sensor histogram testbench

VERILATOR ?= verilator
TOP       ?= tb_sens_histogram
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) common/hist_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- accum/hist_accum.sv
/*
 * histogram accumulator
 * 1024 x 32 count RAM with a 3-stage read-increment-write pipeline,
 * forwarding in-flight counts to back-to-back hits on one bin.
 * readout port returns a count and clears the bin in the same access
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_accum (
    input  logic                  pclk,
    input  logic                  hist_rst_pclk,
    input  hist_pkg::tagged_pix_t pix_i,
    input  logic                  rd_en_i,
    input  hist_pkg::bin_addr_t   rd_addr_i,
    output hist_pkg::hist_cnt_t   hist_do_o,
    output logic                  hist_dv_o
);
    import hist_pkg::*;

    localparam int NUM_BINS = 1 << `HIST_BIN_W;

    hist_cnt_t               mem [NUM_BINS];
    hist_cnt_t               ram_q;     // read data, 1 cycle after address
    bin_addr_t               ram_ra;
    bin_addr_t               ram_wa;
    hist_cnt_t               ram_wd;
    logic                    ram_we;
    tagged_pix_t             pix_d1;    // read data arriving
    tagged_pix_t             pix_d2;    // incremented, writing
    tagged_pix_t             pix_d3;    // just written
    hist_cnt_t               operand;   // count to increment
    hist_cnt_t               inc_r;     // count being written
    hist_cnt_t               wr_q;      // count written last cycle
    logic                    fwd_inc;
    logic                    fwd_wr;
    logic [`HIST_RD_LAT-1:0] rd_sr;     // readout valid pipe

    initial begin
        for (int i = 0; i < NUM_BINS; i++) mem[i] = '0; // bins power up empty
    end

    // readout owns the port while it runs, pixels are blocked then
    assign ram_ra = rd_en_i ? rd_addr_i : pix_i.addr;
    assign ram_we = rd_en_i | pix_d2.valid;
    assign ram_wa = rd_en_i ? rd_addr_i : pix_d2.addr;
    assign ram_wd = rd_en_i ? '0 : inc_r;                   // clear on read

    always_ff @(posedge pclk) begin
        ram_q <= mem[ram_ra];                                // read-first
        if (ram_we) mem[ram_wa] <= ram_wd;
    end

    // RAM value is stale for hits 1 or 2 cycles behind a write
    assign fwd_inc = pix_d1.valid & pix_d2.valid & (pix_d1.addr == pix_d2.addr);
    assign fwd_wr  = pix_d1.valid & pix_d3.valid & (pix_d1.addr == pix_d3.addr);

    always_comb begin
        if (fwd_inc)     operand = inc_r;   // newest count wins
        else if (fwd_wr) operand = wr_q;
        else             operand = ram_q;
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            pix_d1 <= '0;
            pix_d2 <= '0;
            pix_d3 <= '0;
            rd_sr  <= '0;
        end else begin
            pix_d1 <= pix_i;
            pix_d2 <= pix_d1;
            pix_d3 <= pix_d2;
            rd_sr  <= {rd_sr[`HIST_RD_LAT-2:0], rd_en_i};
        end
    end

    always_ff @(posedge pclk) begin
        inc_r <= operand + 1'b1;
        wr_q  <= inc_r;
        if (rd_sr[0]) hist_do_o <= ram_q;   // output register, last latency stage
    end

    assign hist_dv_o = rd_sr[`HIST_RD_LAT-1];

    // window tracking and readout sequencing keep pixels and readout apart
    a_port_excl: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        !(pix_i.valid && rd_en_i))
        else $error("pixel and readout on the RAM port together");

endmodule

//--- accum/hist_readout.sv
/*
 * histogram readout sequencer
 * requests transfer after frame_done, steps bins 0..1023 on each
 * granted cycle and stays busy until the last count leaves
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_readout (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  logic                frame_done_i,
    input  logic                hist_grant_i,
    output logic                hist_rq_o,
    output logic                rd_en_o,
    output hist_pkg::bin_addr_t rd_addr_o,
    output logic                busy_o
);
    logic [`HIST_BIN_W-1:0]  rd_addr_r;
    logic                    last_rd_w;   // bin 1023 read now
    logic [`HIST_RD_LAT-1:0] tail_sr;     // last read travelling to hist_dv_o

    assign rd_en_o   = hist_rq_o & hist_grant_i;  // grant low just pauses
    assign last_rd_w = rd_en_o & (&rd_addr_r);
    assign rd_addr_o = rd_addr_r;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hist_rq_o <= 1'b0;
            busy_o    <= 1'b0;
            rd_addr_r <= '0;
            tail_sr   <= '0;
        end else begin
            if (frame_done_i)   hist_rq_o <= 1'b1;    // pending bins
            else if (last_rd_w) hist_rq_o <= 1'b0;

            if (frame_done_i) rd_addr_r <= '0;
            else if (rd_en_o) rd_addr_r <= rd_addr_r + 1'b1;

            tail_sr <= {tail_sr[`HIST_RD_LAT-2:0], last_rd_w};

            if (frame_done_i)                 busy_o <= 1'b1;
            else if (tail_sr[`HIST_RD_LAT-1]) busy_o <= 1'b0; // last data out
        end
    end

    // reads only happen inside a readout
    a_rd_in_readout: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        rd_en_o |-> busy_o)
        else $error("read outside readout");

endmodule

//--- common/hist_params.svh
/*
 * histogram constants
 * pixel, color and bin widths, count width, window coordinate width,
 * default bayer phase and readout latency
 */
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

`define HIST_PIX_W      8       // sensor pixel bits
`define HIST_COLOR_W    2       // bayer color tag
`define HIST_BIN_W      10      // color + pixel, 1024 bins
`define HIST_CNT_W      32      // one bin count
`define HIST_GEOM_W     16      // one window coordinate

`define HIST_BAYER_XOR  2'b00   // {line, pixel} phase of the bayer pattern
`define HIST_RD_LAT     2       // read address to hist_dv_o

`endif

//--- common/hist_pkg.sv
/*
 * histogram shared types
 * window geometry, bin address, bin count and a tagged pixel
 * as it enters the accumulator
 */
`include "hist_params.svh"

package hist_pkg;

    typedef struct packed {
        logic [`HIST_GEOM_W-1:0] top;        // lines skipped before window
        logic [`HIST_GEOM_W-1:0] left;       // pixels skipped before window
        logic [`HIST_GEOM_W-1:0] height_m1;  // window lines - 1
        logic [`HIST_GEOM_W-1:0] width_m1;   // window pixels - 1
    } hist_window_t;

    typedef struct packed {
        logic [`HIST_COLOR_W-1:0] color;  // high part of bin index
        logic [`HIST_PIX_W-1:0]   pixel;  // low part
    } bin_addr_t;

    typedef logic [`HIST_CNT_W-1:0] hist_cnt_t;

    typedef struct packed {
        logic      valid;  // pixel inside window, count it
        bin_addr_t addr;
    } tagged_pix_t;

endpackage

//--- list.f
+incdir+common
common/hist_pkg.sv
window/woi_tracker.sv
logic/bayer_tagger.sv
accum/hist_accum.sv
accum/hist_readout.sv
logic/sens_histogram.sv
tb/tb_sens_histogram.sv

//--- logic/bayer_tagger.sv
/*
 * bayer color tagger
 * tracks pixel and line parity, applies the pattern phase and
 * registers each pixel with its color as a bin address
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module bayer_tagger #(
    parameter logic [`HIST_COLOR_W-1:0] bayer_xor = `HIST_BAYER_XOR
) (
    input  logic                  pclk,
    input  logic                  hist_rst_pclk,
    input  logic                  sof_i,
    input  logic                  hact_i,
    input  logic [`HIST_PIX_W-1:0] pixel_i,
    input  logic                  monochrome_i,
    output hist_pkg::bin_addr_t   bin_o
);
    logic hact_d;
    logic pix_phase;  // color[0] of current pixel
    logic line_phase; // color[1] of current line

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d     <= 1'b0;
            pix_phase  <= bayer_xor[0];
            line_phase <= bayer_xor[1];
        end else begin
            hact_d <= hact_i;
            if (sof_i || !hact_i) pix_phase <= bayer_xor[0]; // pixel 0 phase during gaps
            else                  pix_phase <= ~pix_phase;
            if (sof_i)                line_phase <= bayer_xor[1]; // line 0
            else if (!hact_i && hact_d) line_phase <= ~line_phase;  // line end
        end
    end

    // pixel with its color as bin address
    always_ff @(posedge pclk) begin
        bin_o.color <= monochrome_i ? '0 : {line_phase, pix_phase};
        bin_o.pixel <= pixel_i;
    end

endmodule

//--- logic/sens_histogram.sv
/*
 * per-color sensor histogram, top level
 * window tracker and bayer tagger feed the bin accumulator,
 * readout sequencer streams and clears the bins after each frame
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module sens_histogram (
    input  logic                   pclk,
    input  logic                   hist_rst_pclk,
    input  logic                   sof_i,
    input  logic                   hact_i,
    input  logic [`HIST_PIX_W-1:0] pixel_i,
    input  hist_pkg::hist_window_t window_i,
    input  logic                   monochrome_i,
    input  logic                   hist_en_i,
    input  logic                   hist_grant_i,
    output logic                   hist_rq_o,
    output hist_pkg::hist_cnt_t    hist_do_o,
    output logic                   hist_dv_o
);
    import hist_pkg::*;

    logic        in_woi;      // aligned with bin
    logic        frame_done;
    logic        busy;
    logic        rd_en;
    bin_addr_t   rd_addr;
    bin_addr_t   bin;
    tagged_pix_t tagged_pix;

    assign tagged_pix.valid = in_woi;
    assign tagged_pix.addr  = bin;

    woi_tracker woi_tracker_inst (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sof_i         (sof_i),
        .hact_i        (hact_i),
        .window_i      (window_i),
        .hist_en_i     (hist_en_i),
        .busy_i        (busy),
        .in_woi_o      (in_woi),
        .frame_done_o  (frame_done)
    );

    bayer_tagger bayer_tagger_inst (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sof_i         (sof_i),
        .hact_i        (hact_i),
        .pixel_i       (pixel_i),
        .monochrome_i  (monochrome_i),
        .bin_o         (bin)
    );

    hist_accum hist_accum_inst (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_i         (tagged_pix),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .hist_do_o     (hist_do_o),
        .hist_dv_o     (hist_dv_o)
    );

    hist_readout hist_readout_inst (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .frame_done_i  (frame_done),
        .hist_grant_i  (hist_grant_i),
        .hist_rq_o     (hist_rq_o),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .busy_o        (busy)
    );

endmodule

//--- tb/tb_sens_histogram.sv
/*
 * sensor histogram testbench
 * sends LCG frames through sens_histogram, builds the expected bins
 * from the window and bayer rules, and checks every readout word in order
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module tb_sens_histogram;
    import hist_pkg::*;

    localparam int NUM_BINS  = 1 << `HIST_BIN_W;
    localparam int MAX_LINES = 16;
    localparam int MAX_PIX   = 32;

    logic                   pclk = 1'b0;
    logic                   hist_rst_pclk;
    logic                   sof_i;
    logic                   hact_i;
    logic [`HIST_PIX_W-1:0] pixel_i;
    hist_window_t           window_i;
    logic                   monochrome_i;
    logic                   hist_en_i;
    logic                   hist_grant_i;
    logic                   hist_rq_o;
    hist_cnt_t              hist_do_o;
    logic                   hist_dv_o;

    logic [`HIST_PIX_W-1:0] frame_pix [MAX_LINES][MAX_PIX]; // stored frame
    hist_cnt_t              exp_bins [NUM_BINS];            // reference histogram
    logic [31:0]            lcg_state;
    logic                   expect_data;                    // readout due from a counted frame
    int                     rx_idx = 0;                     // next bin on hist_dv_o
    int                     cmp_errors = 0;
    int                     chk_errors;
    int                     tests_run;
    int                     tests_failed;
    bit                     timed_out;

    always #10 pclk = ~pclk;  // 50 MHz

    sens_histogram sens_histogram_inst (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sof_i         (sof_i),
        .hact_i        (hact_i),
        .pixel_i       (pixel_i),
        .window_i      (window_i),
        .monochrome_i  (monochrome_i),
        .hist_en_i     (hist_en_i),
        .hist_grant_i  (hist_grant_i),
        .hist_rq_o     (hist_rq_o),
        .hist_do_o     (hist_do_o),
        .hist_dv_o     (hist_dv_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic hist_window_t make_window(input logic [15:0] top, input logic [15:0] left,
                                                 input logic [15:0] h_m1, input logic [15:0] w_m1);
        hist_window_t w;
        w.top       = top;
        w.left      = left;
        w.height_m1 = h_m1;
        w.width_m1  = w_m1;
        return w;
    endfunction

    // expected bins from a window test per pixel and color from line/pixel parity
    function automatic void ref_hist(input int n_lines, input int n_pix,
                                     input hist_window_t win, input logic mono);
        bin_addr_t  b;
        logic [1:0] phase;
        phase = `HIST_BAYER_XOR;
        for (int i = 0; i < NUM_BINS; i++)
            exp_bins[i] = '0;
        for (int l = 0; l < n_lines; l++) begin
            for (int p = 0; p < n_pix; p++) begin
                if (l >= int'(win.top) && l <= int'(win.top) + int'(win.height_m1) &&
                    p >= int'(win.left) && p <= int'(win.left) + int'(win.width_m1)) begin
                    b.color = mono ? 2'b00 : {l[0] ^ phase[1], p[0] ^ phase[0]};
                    b.pixel = frame_pix[l][p];
                    exp_bins[b] = exp_bins[b] + 32'd1;
                end
            end
        end
    endfunction

    // random pixels where about half repeat the previous one (same-bin runs)
    task automatic gen_frame(input int n_lines, input int n_pix);
        logic [`HIST_PIX_W-1:0] prev;
        prev = '0;
        for (int l = 0; l < n_lines; l++) begin
            for (int p = 0; p < n_pix; p++) begin
                lcg_state = lcg_next(lcg_state);
                if (!lcg_state[20])
                    prev = lcg_state[31:24];
                frame_pix[l][p] = prev;
            end
        end
    endtask

    task automatic run_frame(input int n_lines, input int n_pix);
        @(posedge pclk);
        sof_i <= 1'b1;
        @(posedge pclk);
        sof_i <= 1'b0;
        repeat (3) @(posedge pclk);                  // lead-in before line 0
        for (int l = 0; l < n_lines; l++) begin
            for (int p = 0; p < n_pix; p++) begin
                @(posedge pclk);
                hact_i  <= 1'b1;
                pixel_i <= frame_pix[l][p];
            end
            repeat (4) begin
                @(posedge pclk);
                hact_i <= 1'b0;                      // line gap
            end
        end
    endtask

    task automatic wait_readout(input bit rand_grant);
        int t;
        t = 0;
        while (hist_rq_o !== 1'b1 && t < 64) begin
            @(posedge pclk);
            t++;
        end
        assert (hist_rq_o === 1'b1) else begin
            $display("timeout: hist_rq_o did not rise after the frame");
            chk_errors++;
            timed_out = 1'b1;
        end
        t = 0;
        while (!timed_out && rx_idx < NUM_BINS && t < 20000) begin
            @(posedge pclk);
            lcg_state = lcg_next(lcg_state);
            hist_grant_i <= rand_grant ? lcg_state[16] : 1'b1; // back-pressure
            t++;
        end
        hist_grant_i <= 1'b1;
        if (!timed_out) begin
            assert (rx_idx == NUM_BINS) else begin
                $display("timeout: only %0d of %0d bins arrived", rx_idx, NUM_BINS);
                chk_errors++;
                timed_out = 1'b1;
            end
            assert (hist_rq_o === 1'b0) else begin
                $display("Error: %0d ns hist_rq_o expected 0 actual %b", $time, hist_rq_o);
                chk_errors++;
            end
        end
    endtask

    // no request and no data for a whole window of cycles
    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge pclk);
            assert (hist_rq_o === 1'b0 && hist_dv_o === 1'b0) else begin
                $display("Error: %0d ns hist_rq_o/hist_dv_o expected 0/0 actual %b/%b",
                         $time, hist_rq_o, hist_dv_o);
                chk_errors++;
            end
        end
    endtask

    task automatic report(input string name, input int errs_before);
        int errs;
        errs = cmp_errors + chk_errors - errs_before;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %-26s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
    endtask

    task automatic run_test(input string name, input int n_lines, input int n_pix,
                            input hist_window_t win, input logic mono, input logic en,
                            input bit rand_grant);
        int errs_before;
        errs_before = cmp_errors + chk_errors;
        expect_data = 1'b0;
        repeat (2) @(posedge pclk);                  // compare process rewinds rx_idx
        window_i     <= win;
        monochrome_i <= mono;
        hist_en_i    <= en;
        gen_frame(n_lines, n_pix);
        ref_hist(n_lines, n_pix, win, mono);
        expect_data = en;
        run_frame(n_lines, n_pix);
        if (en)
            wait_readout(rand_grant);
        else
            check_idle(200);
        report(name, errs_before);
    endtask

    // words checked by position starting at bin 0
    always @(posedge pclk) begin
        if (hist_rst_pclk || !expect_data)
            rx_idx <= 0;
        if (!hist_rst_pclk && hist_dv_o) begin
            assert (expect_data && rx_idx < NUM_BINS) else begin
                $display("%0d ns: hist_dv_o word outside a readout or past the last bin",
                         $time);
                cmp_errors++;
            end
            if (expect_data && rx_idx < NUM_BINS) begin
                assert (hist_do_o === exp_bins[rx_idx]) else begin
                    $display("Error: %0d ns hist_do_o bin %0d expected %0d actual %0d",
                             $time, rx_idx, exp_bins[rx_idx], hist_do_o);
                    cmp_errors++;
                end
                rx_idx <= rx_idx + 1;
            end
        end
    end

    initial begin
        hist_rst_pclk = 1'b1;
        sof_i         = 1'b0;
        hact_i        = 1'b0;
        pixel_i       = '0;
        window_i      = '0;
        monochrome_i  = 1'b0;
        hist_en_i     = 1'b0;
        hist_grant_i  = 1'b1;
        lcg_state     = 32'h9d1dc355;
        expect_data   = 1'b0;
        chk_errors    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;
        repeat (16) @(posedge pclk);
        hist_rst_pclk <= 1'b0;
        check_idle(20);
        report("reset state", 0);
        if (!timed_out)
            run_test("mono full window", 9, 24, make_window(0, 0, 7, 23), 1'b1, 1'b1, 1'b0);
        if (!timed_out)
            run_test("bayer full window", 9, 24, make_window(0, 0, 7, 23), 1'b0, 1'b1, 1'b0);
        if (!timed_out)
            run_test("offset window", 8, 20, make_window(3, 5, 3, 6), 1'b0, 1'b1, 1'b0);
        if (!timed_out)
            run_test("two frames, first", 7, 16, make_window(0, 0, 5, 15), 1'b0, 1'b1, 1'b0);
        if (!timed_out)
            run_test("two frames, second", 7, 16, make_window(0, 0, 5, 15), 1'b0, 1'b1, 1'b0);
        if (!timed_out)
            run_test("random grant", 9, 24, make_window(0, 0, 7, 23), 1'b0, 1'b1, 1'b1);
        if (!timed_out)
            run_test("histogram disabled", 9, 24, make_window(0, 0, 7, 23), 1'b0, 1'b0, 1'b0);
        $display("%0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, cmp_errors + chk_errors);
        if (timed_out || cmp_errors + chk_errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

//--- window/woi_tracker.sv
/*
 * window of interest tracker
 * samples window geometry at sof, walks lines and pixels with down-counters
 * and flags pixels inside the window one cycle after they arrive.
 * pulses frame_done at the first line start after the window
 */
`timescale 1ns/1ps
`include "hist_params.svh"

module woi_tracker (
    input  logic                   pclk,
    input  logic                   hist_rst_pclk,
    input  logic                   sof_i,
    input  logic                   hact_i,
    input  hist_pkg::hist_window_t window_i,
    input  logic                   hist_en_i,
    input  logic                   busy_i,        // readout still running
    output logic                   in_woi_o,
    output logic                   frame_done_o
);
    import hist_pkg::*;

    hist_window_t            win_r;          // geometry of current frame
    logic                    hact_d;
    logic                    line_start_w;
    logic                    frame_start_w;
    logic                    frame_active;   // counted frame, until done
    logic                    top_margin;     // above the window
    logic                    vert_woi;       // lines inside the window
    logic                    left_margin;    // left of the window
    logic                    hor_woi;        // pixels inside the window
    logic [`HIST_GEOM_W-1:0] vcntr;          // lines to go
    logic [`HIST_GEOM_W-1:0] hcntr;          // pixels to go
    logic                    vcntr_zero_w;
    logic                    line_woi_w;     // current line vertically inside
    logic                    lm_w;           // current pixel in left margin
    logic                    hw_w;           // current pixel inside
    logic [`HIST_GEOM_W-1:0] hc_w;           // current pixel count
    logic                    lm_nx;
    logic                    hw_nx;
    logic [`HIST_GEOM_W-1:0] hc_nx;

    assign line_start_w  = hact_i & ~hact_d;
    assign frame_start_w = sof_i & hist_en_i & ~busy_i; // no new frame during readout
    assign vcntr_zero_w  = ~|vcntr;

    // line state must already hold for pixel 0, so look ahead at line start
    always_comb begin
        if (!line_start_w)   line_woi_w = vert_woi;
        else if (top_margin) line_woi_w = vcntr_zero_w;             // first window line
        else                 line_woi_w = vert_woi & ~vcntr_zero_w; // last line passed
    end

    always_comb begin
        if (line_start_w) begin                  // reload from sampled window
            lm_w = |win_r.left;
            hw_w = ~|win_r.left;
            hc_w = lm_w ? win_r.left - 1'b1 : win_r.width_m1;
        end else begin
            lm_w = left_margin;
            hw_w = hor_woi;
            hc_w = hcntr;
        end
        lm_nx = lm_w & (|hc_w);
        hw_nx = lm_w ? ~|hc_w : (hw_w & (|hc_w));
        hc_nx = (lm_w && !(|hc_w)) ? win_r.width_m1 : hc_w - 1'b1;
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d       <= 1'b0;
            frame_active <= 1'b0;
            top_margin   <= 1'b0;
            vert_woi     <= 1'b0;
            left_margin  <= 1'b0;
            hor_woi      <= 1'b0;
            in_woi_o     <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            hact_d       <= hact_i;
            frame_done_o <= frame_active & line_start_w & vert_woi & vcntr_zero_w;
            if (sof_i) begin                     // any sof restarts, counted or not
                frame_active <= frame_start_w;
                top_margin   <= frame_start_w;
                vert_woi     <= 1'b0;
            end else if (frame_active && line_start_w && vcntr_zero_w) begin
                if (top_margin) begin
                    top_margin <= 1'b0;
                    vert_woi   <= 1'b1;
                end else if (vert_woi) begin     // line after the window
                    vert_woi     <= 1'b0;
                    frame_active <= 1'b0;
                end
            end
            if (hact_i) begin
                left_margin <= lm_nx;
                hor_woi     <= hw_nx;
            end
            in_woi_o <= frame_active & line_woi_w & hw_w & hact_i & ~busy_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (sof_i && hist_en_i) win_r <= window_i;
        if (sof_i)                                            vcntr <= window_i.top;
        else if (line_start_w && top_margin && vcntr_zero_w) vcntr <= win_r.height_m1;
        else if (line_start_w && !vcntr_zero_w)              vcntr <= vcntr - 1'b1;
        if (hact_i) hcntr <= hc_nx;
    end

    // frames only start while idle, so done never lands in a readout
    a_done_idle: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        $rose(frame_done_o) |-> !busy_i)
        else $error("frame_done during readout");

endmodule
